/* Bender.yml */
package:
  name: mul_simd

sources:
  - files:
      - rtl/mul_simd_pkg.sv
      - rtl/booth_recoder.sv
      - rtl/pp_row.sv
      - rtl/pp_array.sv
      - rtl/pp_reduce.sv
      - rtl/mul_simd_top.sv
  - target: test
    files:
      - verif/tb_mul_simd.sv

/* mul_simd.f */
rtl/mul_simd_pkg.sv
rtl/booth_recoder.sv
rtl/pp_row.sv
rtl/pp_array.sv
rtl/pp_reduce.sv
rtl/mul_simd_top.sv
verif/tb_mul_simd.sv

/* rtl/booth_recoder.sv */
`timescale 1ns/1ps

module booth_recoder
   import mul_simd_pkg::*;
(
   input  op_e               op,
   input  logic [OPND_W-1:0] mplier,
   output booth_digit_e      digits [NUM_DIGITS],
   output logic [3:0]        corr
);

   logic [OPND_W:0] ext;  // multiplier with a zero below bit 0

   function automatic booth_digit_e decode(input logic [2:0] trip);
      case (trip)
         3'b001, 3'b010: return dig_p1;
         3'b011:         return dig_p2;
         3'b100:         return dig_m2;
         3'b101, 3'b110: return dig_m1;
         default:        return dig_zero;  // 000 and 111
      endcase
   endfunction

   assign ext = {mplier, 1'b0};

   // ~~~~~~~~~~~~~~~~~~~~
   // digit per bit pair
   // ~~~~~~~~~~~~~~~~~~~~
   for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
      logic low;

      // lowest digit of a lane must not look into the lane below
      assign low = ((i % 8 == 0) || ((i % 4 == 0) && (lane_width(op) == 8))) ?
                   1'b0 : ext[2*i];
      assign digits[i] = decode({mplier[2*i+1], mplier[2*i], low});
   end

   // unsigned lanes: booth treats the top bit as sign, so add the
   // multiplicand back in at the lane width when that bit is set
   always_comb begin
      corr = '0;
      if (!op_signed(op)) begin
         if (lane_width(op) == 8) begin
            corr = {mplier[31], mplier[23], mplier[15], mplier[7]};
         end else begin
            corr = {mplier[31], 1'b0, mplier[15], 1'b0};  // top byte of each half
         end
      end
   end

endmodule

/* rtl/mul_simd_pkg.sv */
package mul_simd_pkg;

   // ~~~~~~~~~~~~~~~~~~~~
   // widths
   // ~~~~~~~~~~~~~~~~~~~~
   localparam int OPND_W     = 32;
   localparam int RES_W      = 64;
   localparam int NUM_DIGITS = 16;  // radix-4 digits across one operand
   localparam int ROW_W      = 64;  // a row already sits at its lane and shift

   typedef enum logic [1:0] {
      op_dual16_u = 2'b00,
      op_dual16_s = 2'b01,
      op_quad8_u  = 2'b10,
      op_quad8_s  = 2'b11
   } op_e;

   // booth digit values, multiples of the multiplicand
   typedef enum logic [2:0] {
      dig_zero = 3'd0,
      dig_p1   = 3'd1,
      dig_p2   = 3'd2,
      dig_m1   = 3'd3,
      dig_m2   = 3'd4
   } booth_digit_e;

   // ~~~~~~~~~~~~~~~~~~~~
   // lane mode helpers
   // ~~~~~~~~~~~~~~~~~~~~
   function automatic int unsigned lane_width(input op_e op);
      return (op inside {op_quad8_u, op_quad8_s}) ? 8 : 16;
   endfunction

   function automatic logic op_signed(input op_e op);
      return op inside {op_dual16_s, op_quad8_s};
   endfunction

endpackage

/* rtl/mul_simd_top.sv */
`timescale 1ns/1ps

module mul_simd_top
   import mul_simd_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   input  op_e                op,
   input  logic [OPND_W-1:0]  a,
   input  logic [OPND_W-1:0]  b,
   output logic               out_valid,
   output logic [RES_W-1:0]   result
);

   // stage 1 to stage 2
   logic             rows_valid;
   op_e              rows_op;
   logic [ROW_W-1:0] rows [NUM_DIGITS];
   logic [ROW_W-1:0] corr_rows [4];

   pp_array u_array (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .op         (op),
      .a          (a),
      .b          (b),
      .rows_valid (rows_valid),
      .rows_op    (rows_op),
      .rows       (rows),
      .corr_rows  (corr_rows)
   );

   pp_reduce u_reduce (
      .clk        (clk),
      .rst_n      (rst_n),
      .rows_valid (rows_valid),
      .rows_op    (rows_op),
      .rows       (rows),
      .corr_rows  (corr_rows),
      .out_valid  (out_valid),
      .result     (result)
   );

endmodule

/* rtl/pp_array.sv */
`timescale 1ns/1ps

module pp_array
   import mul_simd_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               in_valid,
   input  op_e                op,
   input  logic [OPND_W-1:0]  a,
   input  logic [OPND_W-1:0]  b,
   output logic               rows_valid,
   output op_e                rows_op,
   output logic [ROW_W-1:0]   rows [NUM_DIGITS],
   output logic [ROW_W-1:0]   corr_rows [4]
);

   booth_digit_e     digits [NUM_DIGITS];
   logic [3:0]       corr;
   logic [ROW_W-1:0] row_d [NUM_DIGITS];
   logic [ROW_W-1:0] corr_d [4];

   // a is the multiplier, b the multiplicand
   booth_recoder u_recoder (
      .op     (op),
      .mplier (a),
      .digits (digits),
      .corr   (corr)
   );

   for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_row
      pp_row u_row (
         .op    (op),
         .digit (digits[i]),
         .mcand (b),
         .pos   (4'(i)),
         .row   (row_d[i])
      );
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // correction rows
   // ~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         corr_d[k] = '0;
      end
      if (lane_width(op) == 8) begin
         for (int k = 0; k < 4; k++) begin
            if (corr[k]) corr_d[k][16*k +: 16] = {b[8*k +: 8], 8'h00};
         end
      end else begin
         for (int l = 0; l < 2; l++) begin
            if (corr[2*l+1]) corr_d[2*l+1][32*l +: 32] = {b[16*l +: 16], 16'h0000};
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rows_valid <= 1'b0;
      end else begin
         rows_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin  // hold otherwise
         rows_op   <= op;
         rows      <= row_d;
         corr_rows <= corr_d;
      end
   end

   a_op_known : assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> !$isunknown(op));

endmodule

/* rtl/pp_reduce.sv */
`timescale 1ns/1ps

module pp_reduce
   import mul_simd_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              rows_valid,
   input  op_e               rows_op,
   input  logic [ROW_W-1:0]  rows [NUM_DIGITS],
   input  logic [ROW_W-1:0]  corr_rows [4],
   output logic              out_valid,
   output logic [RES_W-1:0]  result
);

   logic [20:0]      acc;    // 20 rows of 16 bits plus carry in
   logic [4:0]       carry;
   logic [RES_W-1:0] sum_d;

   // ~~~~~~~~~~~~~~~~~~~~
   // segmented sum
   // ~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      carry = '0;
      acc   = '0;
      for (int s = 0; s < 4; s++) begin
         acc = 21'(carry);
         for (int r = 0; r < NUM_DIGITS; r++) begin
            acc = acc + 21'(rows[r][16*s +: 16]);
         end
         for (int r = 0; r < 4; r++) begin
            acc = acc + 21'(corr_rows[r][16*s +: 16]);
         end
         sum_d[16*s +: 16] = acc[15:0];
         // only the middle of a 16x16 lane passes a carry up
         carry = ((lane_width(rows_op) == 16) && (s % 2 == 0)) ? acc[20:16] : 5'd0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= rows_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (rows_valid) result <= sum_d;
   end

   // a valid result never carries unknown bits from the rows
   a_result_known : assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> !$isunknown(result));

endmodule

/* rtl/pp_row.sv */
`timescale 1ns/1ps

module pp_row
   import mul_simd_pkg::*;
(
   input  op_e               op,
   input  booth_digit_e      digit,
   input  logic [OPND_W-1:0] mcand,
   input  logic [3:0]        pos,
   output logic [ROW_W-1:0]  row
);

   logic        wide;
   logic [15:0] m16;
   logic [7:0]  m8;
   logic        sgn;
   logic [31:0] m_ext;    // lane multiplicand at twice the lane width
   logic [31:0] m_mul;
   logic [3:0]  shamt;
   logic [31:0] m_shift;

   assign wide = (lane_width(op) == 16);

   // lane select, 8 digits per half or 4 per byte
   assign m16   = mcand[16*pos[3] +: 16];
   assign m8    = mcand[8*pos[3:2] +: 8];
   assign sgn   = op_signed(op) & (wide ? m16[15] : m8[7]);
   assign m_ext = wide ? {{16{sgn}}, m16} : {{24{sgn}}, m8};

   always_comb begin
      case (digit)
         dig_p1:  m_mul = m_ext;
         dig_p2:  m_mul = m_ext << 1;
         dig_m1:  m_mul = ~m_ext + 32'd1;
         dig_m2:  m_mul = ~(m_ext << 1) + 32'd1;
         default: m_mul = '0;
      endcase
   end

   assign shamt   = wide ? {pos[2:0], 1'b0} : {1'b0, pos[1:0], 1'b0};
   assign m_shift = m_mul << shamt;

   // ~~~~~~~~~~~~~~~~~~~~
   // place within result
   // ~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      row = '0;
      if (wide) begin
         row[32*pos[3] +: 32] = m_shift;
      end else begin
         row[16*pos[3:2] +: 16] = m_shift[15:0];  // truncated to the byte lane product
      end
   end

endmodule

/* verif/tb_mul_simd.sv */
`timescale 1ns/1ps

module tb_mul_simd
   import mul_simd_pkg::*;
();

   localparam int NUM_RANDOM = 200;
   localparam int LATENCY    = 2;

   logic              clk;
   logic              rst_n;
   logic              in_valid;
   op_e               op;
   logic [OPND_W-1:0] a;
   logic [OPND_W-1:0] b;
   logic              out_valid;
   logic [RES_W-1:0]  result;

   // stimulus table
   string             t_name [$];
   logic              t_valid [$];
   op_e               t_op [$];
   logic [OPND_W-1:0] t_a [$];
   logic [OPND_W-1:0] t_b [$];
   logic              table_ready = 1'b0;

   // requests in flight
   logic [RES_W-1:0]  exp_q [$];
   string             name_q [$];
   int                issue_q [$];

   int edge_cnt     = 0;
   int checks       = 0;
   int value_errs   = 0;
   int latency_errs = 0;
   int other_errs   = 0;

   mul_simd_top uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .op        (op),
      .a         (a),
      .b         (b),
      .out_valid (out_valid),
      .result    (result)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) edge_cnt <= edge_cnt + 1;

   // ~~~~~~~~~~~~~~~~~~~~
   // reference model
   // ~~~~~~~~~~~~~~~~~~~~
   function automatic logic [RES_W-1:0] lane_product(input op_e m_op,
                                                     input logic [OPND_W-1:0] m_a,
                                                     input logic [OPND_W-1:0] m_b);
      logic [RES_W-1:0] res;
      longint           pa;
      longint           pb;
      longint           p;
      bit               sgn;
      bit               byte_mode;
      res       = '0;
      sgn       = (m_op == op_dual16_s) || (m_op == op_quad8_s);
      byte_mode = (m_op == op_quad8_u) || (m_op == op_quad8_s);
      if (byte_mode) begin
         for (int k = 0; k < 4; k++) begin
            pa = {{56{sgn & m_a[8*k+7]}}, m_a[8*k +: 8]};
            pb = {{56{sgn & m_b[8*k+7]}}, m_b[8*k +: 8]};
            p  = pa * pb;
            res[16*k +: 16] = p[15:0];
         end
      end else begin
         for (int k = 0; k < 2; k++) begin
            pa = {{48{sgn & m_a[16*k+15]}}, m_a[16*k +: 16]};
            pb = {{48{sgn & m_b[16*k+15]}}, m_b[16*k +: 16]};
            p  = pa * pb;
            res[32*k +: 32] = p[31:0];
         end
      end
      return res;
   endfunction

   task automatic check_result(input string name, input logic [RES_W-1:0] exp_v,
                               input logic [RES_W-1:0] act_v);
      checks++;
      if (act_v !== exp_v) begin
         value_errs++;
         $display("ERROR %s: expected %h, actual %h", name, exp_v, act_v);
      end
   endtask

   task automatic check_latency(input string name, input int exp_v, input int act_v);
      checks++;
      if (act_v != exp_v) begin
         latency_errs++;
         $display("ERROR %s latency: expected %0d, actual %0d", name, exp_v, act_v);
      end
   endtask

   task automatic add_entry(input string name, input logic valid, input op_e e_op,
                            input logic [OPND_W-1:0] e_a, input logic [OPND_W-1:0] e_b);
      t_name.push_back(name);
      t_valid.push_back(valid);
      t_op.push_back(e_op);
      t_a.push_back(e_a);
      t_b.push_back(e_b);
   endtask

   task automatic load_table();
      add_entry("d16u_max",      1'b1, op_dual16_u, 32'hffff_ffff, 32'hffff_ffff);
      add_entry("d16u_zero_a",   1'b1, op_dual16_u, 32'h0000_0000, 32'h1234_abcd);
      add_entry("d16u_zero_b",   1'b1, op_dual16_u, 32'hbeef_8001, 32'h0000_0000);
      add_entry("d16u_mixed",    1'b1, op_dual16_u, 32'h8000_1234, 32'hffff_0002);
      add_entry("idle",          1'b0, op_dual16_u, 32'h0, 32'h0);
      add_entry("d16s_min_min",  1'b1, op_dual16_s, 32'h8000_8000, 32'h8000_8000);
      add_entry("d16s_neg1_pos1", 1'b1, op_dual16_s, 32'hffff_ffff, 32'h0001_0001);
      add_entry("d16s_mixed",    1'b1, op_dual16_s, 32'h7fff_8001, 32'h8000_7fff);
      add_entry("idle",          1'b0, op_dual16_u, 32'h0, 32'h0);
      add_entry("idle",          1'b0, op_dual16_u, 32'h0, 32'h0);
      add_entry("q8u_max",       1'b1, op_quad8_u,  32'hffff_ffff, 32'hffff_ffff);
      add_entry("q8u_neighbors", 1'b1, op_quad8_u,  32'h00ff_00ff, 32'h01ff_03ff);
      add_entry("q8s_min_min",   1'b1, op_quad8_s,  32'h8080_8080, 32'h8080_8080);
      add_entry("q8s_mixed",     1'b1, op_quad8_s,  32'h7f80_ff01, 32'h8080_7f7f);
      add_entry("q8s_neighbors", 1'b1, op_quad8_s,  32'h0080_0080, 32'h0180_ff80);
      add_entry("idle",          1'b0, op_dual16_u, 32'h0, 32'h0);
      // back to back, op changes every cycle
      add_entry("b2b_d16u",      1'b1, op_dual16_u, 32'hc0de_1357, 32'h9abc_0fed);
      add_entry("b2b_q8s",       1'b1, op_quad8_s,  32'h81c3_7e24, 32'hf00f_a55a);
      add_entry("b2b_d16s",      1'b1, op_dual16_s, 32'h8765_4321, 32'hfedc_ba98);
      add_entry("b2b_q8u",       1'b1, op_quad8_u,  32'hd1e2_f304, 32'h5a6b_7c8d);
      add_entry("idle",          1'b0, op_dual16_u, 32'h0, 32'h0);
   endtask

   // one table row per cycle, 1 ns after the edge
   task automatic apply_entry(input string name, input logic valid, input op_e e_op,
                              input logic [OPND_W-1:0] e_a, input logic [OPND_W-1:0] e_b);
      @(posedge clk);
      #1;
      in_valid = valid;
      op       = e_op;
      a        = e_a;
      b        = e_b;
      if (valid) begin
         exp_q.push_back(lane_product(e_op, e_a, e_b));
         name_q.push_back(name);
         issue_q.push_back(edge_cnt);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // output monitor
   // ~~~~~~~~~~~~~~~~~~~~
   always @(negedge clk) begin : monitor
      logic [RES_W-1:0] exp_v;
      string            name;
      int               issued;
      if (!rst_n) begin
         if (out_valid !== 1'b0) begin
            other_errs++;
            $display("out_valid is high during reset");
         end
      end else if ($isunknown(out_valid)) begin
         other_errs++;
         $display("out_valid is unknown after reset");
      end else if (out_valid) begin
         if (exp_q.size() == 0) begin
            other_errs++;
            $display("out_valid with no request pending");
         end else begin
            exp_v  = exp_q.pop_front();
            name   = name_q.pop_front();
            issued = issue_q.pop_front();
            check_result(name, exp_v, result);
            check_latency(name, LATENCY, edge_cnt - issued);
         end
      end
   end

   initial begin : stimulus
      op_e               r_op;
      logic [OPND_W-1:0] r_a;
      logic [OPND_W-1:0] r_b;
      rst_n    = 1'b0;
      in_valid = 1'b0;
      op       = op_dual16_u;
      a        = '0;
      b        = '0;
      void'($urandom(32'hf2f5));
      load_table();
      table_ready = 1'b1;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      @(negedge clk);
      if (out_valid !== 1'b0) begin
         other_errs++;
         $display("out_valid is not low after reset");
      end
      for (int i = 0; i < t_name.size(); i++) begin
         apply_entry(t_name[i], t_valid[i], t_op[i], t_a[i], t_b[i]);
      end
      for (int i = 0; i < NUM_RANDOM; i++) begin
         r_op = op_e'($urandom_range(3, 0));
         r_a  = $urandom;
         r_b  = $urandom;
         apply_entry($sformatf("rand_%0d", i), 1'b1, r_op, r_a, r_b);
      end
      apply_entry("drain", 1'b0, op_dual16_u, '0, '0);
      while (exp_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);  // idle tail, monitor still watching
      $display("checks %0d, value errors %0d, latency errors %0d, other errors %0d",
               checks, value_errs, latency_errs, other_errs);
      if (value_errs + latency_errs + other_errs == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin : watchdog
      wait (table_ready);
      #((t_name.size() + NUM_RANDOM + 20) * 8);
      $display("timeout, the run did not finish in time with %0d results pending",
               exp_q.size());
      $display("Errors found");
      $finish;
   end

endmodule
